/* common/dbg_biu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Debug bus interface unit shared definitions
// Bus widths and vector types, debug word size codes, the big-endian
// byte-lane select for full words and the bus-side state encoding
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package dbg_biu_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  // One select bit per byte lane
  localparam int SEL_W       = DATA_W / 8;
  localparam int WORD_SIZE_W = 3;

  // Byte address on the system bus
  typedef logic [ADDR_W-1:0]      addr_t;
  // Bus data word
  typedef logic [DATA_W-1:0]      data_t;
  // Lane select, bit 3 is the lowest address (big endian)
  typedef logic [SEL_W-1:0]       sel_t;
  // Access size in bytes as sent by the debug port
  typedef logic [WORD_SIZE_W-1:0] word_size_t;

  //////////////////////////////////////////////////////////////////////////
  // Word size codes
  //////////////////////////////////////////////////////////////////////////

  // Any other code is handled as a full word
  localparam word_size_t WORD_SIZE_BYTE = 3'd1;
  localparam word_size_t WORD_SIZE_HALF = 3'd2;
  localparam word_size_t WORD_SIZE_WORD = 3'd4;

  // All four lanes enabled
  localparam sel_t SEL_WORD = 4'b1111;

  //////////////////////////////////////////////////////////////////////////
  // Bus-side state machine
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [0:0] {
    BIU_IDLE = 1'b0,
    BIU_XFER = 1'b1
  } biu_state_e;

endpackage

`default_nettype wire

/* common/dbg_biu_xfer_if.sv */
////////////////////////////////////////////////////////////////////////////
// Request and response bundle between the JTAG and bus clock domains
// Toggle handshake in each direction plus the quasi-static payload
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface dbg_biu_xfer_if;

  // Request, owned by the JTAG side
  // A level change on req_toggle announces one new request
  logic                 req_toggle;
  dbg_biu_pkg::sel_t    sel;
  dbg_biu_pkg::addr_t   addr;
  dbg_biu_pkg::data_t   wdata;
  logic                 we;

  // Response, owned by the bus side
  // rdata and err only change together with rsp_toggle
  logic                 rsp_toggle;
  dbg_biu_pkg::data_t   rdata;
  logic                 err;

  // JTAG clock side
  modport tck_mp (
    output req_toggle, sel, addr, wdata, we,
    input  rsp_toggle, rdata, err
  );

  // Bus clock side
  modport wb_mp (
    input  req_toggle, sel, addr, wdata, we,
    output rsp_toggle, rdata, err
  );

endinterface

`default_nettype wire

/* biu/dbg_biu_tck_side.sv */
////////////////////////////////////////////////////////////////////////////
// JTAG clock side of the debug bus interface unit
// Byte-lane decode, write data lane placement, request capture and
// request toggle, response toggle synchronizer driving rdy_o
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dbg_biu_tck_side (
  input  wire                       tck_i,
  input  wire                       rst_i,
  input  wire                       strobe_i,
  input  wire                       rd_wrn_i,
  input  dbg_biu_pkg::data_t        data_i,
  input  dbg_biu_pkg::addr_t        addr_i,
  input  dbg_biu_pkg::word_size_t   word_size_i,
  output logic                      rdy_o,
  dbg_biu_xfer_if.tck_mp            xfer
);

  // Decoded lanes and lane-aligned write data, unregistered
  dbg_biu_pkg::sel_t  be_dec;
  dbg_biu_pkg::data_t wdata_lane;

  // Strobe taken only while idle
  logic accept;

  // Response toggle synchronizer and edge register
  logic rsp_sync_ff1;
  logic rsp_sync_ff2;
  logic rsp_sync_ff2q;

  assign accept = strobe_i & rdy_o;

  ////////////////////////////////////////////////////////////////////////////
  // Byte-lane decode
  ////////////////////////////////////////////////////////////////////////////

  // Big endian, lowest address sits in the top byte of the bus
  always_comb begin
    case (word_size_i)
      dbg_biu_pkg::WORD_SIZE_BYTE: begin
        case (addr_i[1:0])
          2'b00:   be_dec = 4'b1000;
          2'b01:   be_dec = 4'b0100;
          2'b10:   be_dec = 4'b0010;
          default: be_dec = 4'b0001;
        endcase
      end
      dbg_biu_pkg::WORD_SIZE_HALF: begin
        // Address bit 1 picks the half
        if (addr_i[1]) begin
          be_dec = 4'b0011;
        end else begin
          be_dec = 4'b1100;
        end
      end
      dbg_biu_pkg::WORD_SIZE_WORD: be_dec = dbg_biu_pkg::SEL_WORD;
      // Unknown sizes fall back to a word
      default: be_dec = dbg_biu_pkg::SEL_WORD;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write data placement
  ////////////////////////////////////////////////////////////////////////////

  // Short values arrive left-justified in data_i
  // Move them onto the selected lanes, zero elsewhere
  always_comb begin
    case (be_dec)
      4'b1000: wdata_lane = {data_i[31:24], 24'h0};
      4'b0100: wdata_lane = {8'h0, data_i[31:24], 16'h0};
      4'b0010: wdata_lane = {16'h0, data_i[31:24], 8'h0};
      4'b0001: wdata_lane = {24'h0, data_i[31:24]};
      4'b1100: wdata_lane = {data_i[31:16], 16'h0};
      4'b0011: wdata_lane = {16'h0, data_i[31:16]};
      default: wdata_lane = data_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////////////////////////////////////////

  // Fields only move with the toggle, so the bus side can
  // sample them once the synchronized toggle arrives
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      xfer.sel        <= '0;
      xfer.addr       <= '0;
      xfer.wdata      <= '0;
      xfer.we         <= 1'b0;
      xfer.req_toggle <= 1'b0;
    end else if (accept) begin
      xfer.sel        <= be_dec;
      xfer.addr       <= addr_i;
      xfer.we         <= ~rd_wrn_i;
      // Reads keep the previous write data
      if (!rd_wrn_i) begin
        xfer.wdata <= wdata_lane;
      end
      xfer.req_toggle <= ~xfer.req_toggle;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Ready handshake
  ////////////////////////////////////////////////////////////////////////////

  // Two flops into tck_i, third one for edge detect
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rsp_sync_ff1  <= 1'b0;
      rsp_sync_ff2  <= 1'b0;
      rsp_sync_ff2q <= 1'b0;
    end else begin
      rsp_sync_ff1  <= xfer.rsp_toggle;
      rsp_sync_ff2  <= rsp_sync_ff1;
      rsp_sync_ff2q <= rsp_sync_ff2;
    end
  end

  // Low from the accepting edge until the response comes back
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rdy_o <= 1'b1;
    end else if (accept) begin
      rdy_o <= 1'b0;
    end else if (rsp_sync_ff2 != rsp_sync_ff2q) begin
      rdy_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* biu/dbg_biu_wb_master.sv */
////////////////////////////////////////////////////////////////////////////
// Bus clock side of the debug bus interface unit
// Request toggle synchronizer, single classic Wishbone cycle FSM,
// read data right alignment, error capture and response toggle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dbg_biu_wb_master (
  input  wire                 biu_clk_i,
  input  wire                 rst_i,
  input  dbg_biu_pkg::data_t  biu_dat_i,
  input  wire                 biu_ack_i,
  input  wire                 biu_err_i,
  output logic                biu_cyc_o,
  output logic                biu_stb_o,
  dbg_biu_xfer_if.wb_mp       xfer
);

  // Request toggle synchronizer and edge register
  logic req_sync_ff1;
  logic req_sync_ff2;
  logic req_sync_ff2q;

  // One-cycle pulse per new request
  logic start;

  // Slave answered, either way
  logic slave_rsp;
  // Cycle ends in this clock
  logic done;
  // Read data is taken in this clock
  logic rdata_en;

  dbg_biu_pkg::biu_state_e state_q;
  dbg_biu_pkg::biu_state_e state_d;

  // Read data shifted down to bit 0
  dbg_biu_pkg::data_t rdata_aligned;

  ////////////////////////////////////////////////////////////////////////////
  // Request synchronizer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge biu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      req_sync_ff1  <= 1'b0;
      req_sync_ff2  <= 1'b0;
      req_sync_ff2q <= 1'b0;
    end else begin
      req_sync_ff1  <= xfer.req_toggle;
      req_sync_ff2  <= req_sync_ff1;
      req_sync_ff2q <= req_sync_ff2;
    end
  end

  assign start = (req_sync_ff2 != req_sync_ff2q);

  ////////////////////////////////////////////////////////////////////////////
  // Cycle FSM
  ////////////////////////////////////////////////////////////////////////////

  assign slave_rsp = biu_ack_i | biu_err_i;

  // cyc and stb come straight from the start pulse so a zero-wait
  // slave finishes in the first clock and the FSM stays idle
  always_comb begin
    state_d   = state_q;
    biu_cyc_o = 1'b0;
    biu_stb_o = 1'b0;
    done      = 1'b0;
    case (state_q)
      dbg_biu_pkg::BIU_IDLE: begin
        if (start) begin
          biu_cyc_o = 1'b1;
          biu_stb_o = 1'b1;
          done      = slave_rsp;
          if (!slave_rsp) begin
            state_d = dbg_biu_pkg::BIU_XFER;
          end
        end
      end
      dbg_biu_pkg::BIU_XFER: begin
        // Wait states just hold the cycle
        biu_cyc_o = 1'b1;
        biu_stb_o = 1'b1;
        done      = slave_rsp;
        if (slave_rsp) begin
          state_d = dbg_biu_pkg::BIU_IDLE;
        end
      end
      default: state_d = dbg_biu_pkg::BIU_IDLE;
    endcase
  end

  always_ff @(posedge biu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= dbg_biu_pkg::BIU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read data alignment
  ////////////////////////////////////////////////////////////////////////////

  // Latched lanes pick the bytes, everything above the access is zero
  always_comb begin
    case (xfer.sel)
      4'b1000: rdata_aligned = {24'h0, biu_dat_i[31:24]};
      4'b0100: rdata_aligned = {24'h0, biu_dat_i[23:16]};
      4'b0010: rdata_aligned = {24'h0, biu_dat_i[15:8]};
      4'b0001: rdata_aligned = {24'h0, biu_dat_i[7:0]};
      4'b1100: rdata_aligned = {16'h0, biu_dat_i[31:16]};
      4'b0011: rdata_aligned = {16'h0, biu_dat_i[15:0]};
      default: rdata_aligned = biu_dat_i;
    endcase
  end

  // Only a read acknowledged without error carries data
  assign rdata_en = done & biu_ack_i & ~xfer.we;

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  // rdata and err settle in the same clock that flips the toggle
  always_ff @(posedge biu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      xfer.rdata      <= '0;
      xfer.err        <= 1'b0;
      xfer.rsp_toggle <= 1'b0;
    end else begin
      if (rdata_en) begin
        xfer.rdata <= rdata_aligned;
      end
      if (done) begin
        // Cleared again by the next good access
        xfer.err        <= biu_err_i;
        xfer.rsp_toggle <= ~xfer.rsp_toggle;
      end
    end
  end

endmodule

`default_nettype wire

/* src/dbg_biu_top.sv */
////////////////////////////////////////////////////////////////////////////
// Debug bus interface unit top level
// JTAG-side request capture and bus-side Wishbone master joined
// through the clock crossing bundle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dbg_biu_top (
  // Debug port, tck_i domain
  input  wire                      tck_i,
  input  wire                      biu_clk_i,
  input  wire                      rst_i,
  input  wire                      strobe_i,
  input  wire                      rd_wrn_i,
  input  dbg_biu_pkg::data_t       data_i,
  input  dbg_biu_pkg::addr_t       addr_i,
  input  dbg_biu_pkg::word_size_t  word_size_i,
  output dbg_biu_pkg::data_t       data_o,
  output logic                     rdy_o,
  output logic                     err_o,

  // Wishbone master, biu_clk_i domain
  input  dbg_biu_pkg::data_t       biu_dat_i,
  input  wire                      biu_ack_i,
  input  wire                      biu_err_i,
  output dbg_biu_pkg::addr_t       biu_adr_o,
  output dbg_biu_pkg::data_t       biu_dat_o,
  output dbg_biu_pkg::sel_t        biu_sel_o,
  output logic                     biu_we_o,
  output logic                     biu_cyc_o,
  output logic                     biu_stb_o
);

  // Crossing bundle between the two clock domains
  dbg_biu_xfer_if i_xfer ();

  dbg_biu_tck_side i_tck_side (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .data_i      (data_i),
    .addr_i      (addr_i),
    .word_size_i (word_size_i),
    .rdy_o       (rdy_o),
    .xfer        (i_xfer.tck_mp)
  );

  dbg_biu_wb_master i_wb_master (
    .biu_clk_i (biu_clk_i),
    .rst_i     (rst_i),
    .biu_dat_i (biu_dat_i),
    .biu_ack_i (biu_ack_i),
    .biu_err_i (biu_err_i),
    .biu_cyc_o (biu_cyc_o),
    .biu_stb_o (biu_stb_o),
    .xfer      (i_xfer.wb_mp)
  );

  // Request fields are held for the whole transfer
  // so they drive the bus without resampling
  assign biu_adr_o = i_xfer.addr;
  assign biu_dat_o = i_xfer.wdata;
  assign biu_sel_o = i_xfer.sel;
  assign biu_we_o  = i_xfer.we;

  // Response is stable once rdy_o is back
  assign data_o = i_xfer.rdata;
  assign err_o  = i_xfer.err;

endmodule

`default_nettype wire

/* testbench/tb_wb_mem_model.sv */
////////////////////////////////////////////////////////////////////////////
// Behavioral Wishbone memory slave for the debug bus interface testbench
// Random wait states, byte-lane writes, error address window
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem_model #(
  parameter logic [31:0] ERR_BASE = 32'h0000_0100,
  parameter logic [31:0] ERR_LAST = 32'h0000_011f
) (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire  [31:0] adr_i,
  input  wire  [31:0] dat_i,
  input  wire  [3:0]  sel_i,
  input  wire         we_i,
  input  wire         cyc_i,
  input  wire         stb_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        err_o,
  output int unsigned cycles_o
);

  // Sixteen words, indexed by word address
  logic [31:0] mem [16];
  logic [31:0] rng_q;
  logic [31:0] rng_next;
  logic [31:0] wait_draw;
  // Wait states for the current cycle and clocks spent so far
  logic [2:0]  waits_q;
  logic [2:0]  wait_cnt_q;
  logic        req;
  logic        in_window;
  logic        last;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  assign rng_next  = xorshift(rng_q);
  // Zero to four wait states
  assign wait_draw = rng_next % 32'd5;

  assign req       = cyc_i & stb_i;
  assign in_window = (adr_i >= ERR_BASE) && (adr_i <= ERR_LAST);
  // Answer in the same clock once the wait states are used up
  assign last      = req && (wait_cnt_q == waits_q);
  assign ack_o     = last & ~in_window;
  assign err_o     = last & in_window;
  assign dat_o     = mem[adr_i[5:2]];

  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rng_q      <= 32'h35b862b0;
      waits_q    <= 3'd0;
      wait_cnt_q <= 3'd0;
      cycles_o   <= 0;
      // Fill value spread over the whole word index
      for (int i = 0; i < 16; i++) begin
        mem[i] <= 32'h9e37_79b9 * (i + 1);
      end
    end else if (last) begin
      rng_q      <= rng_next;
      waits_q    <= wait_draw[2:0];
      wait_cnt_q <= 3'd0;
      cycles_o   <= cycles_o + 1;
      // Error responses leave the memory untouched
      if (we_i && !in_window) begin
        for (int b = 0; b < 4; b++) begin
          if (sel_i[b]) begin
            mem[adr_i[5:2]][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
    end else if (req) begin
      wait_cnt_q <= wait_cnt_q + 3'd1;
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_dbg_biu.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the debug bus interface unit
// Clocks and reset, stimulus table with its loop, Wishbone cycle monitor,
// value check task and closing report
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_dbg_biu;

  localparam int          RDY_TIMEOUT = 64;
  localparam int          BUS_TIMEOUT = 32;
  localparam logic [31:0] ERR_BASE    = 32'h0000_0100;
  localparam logic [31:0] ERR_LAST    = 32'h0000_011f;
  localparam bit          RD          = 1'b1;
  localparam bit          WR          = 1'b0;
  localparam logic [2:0]  SZ_B        = 3'd1;
  localparam logic [2:0]  SZ_H        = 3'd2;
  localparam logic [2:0]  SZ_W        = 3'd4;

  // One access with its expected bus fields and response
  typedef struct packed {
    logic        rd;
    logic [2:0]  size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  sel;
    logic [31:0] bus_wdata;
    logic [31:0] rdata;
    logic        err;
    logic        dup;
  } vec_t;

  logic        tck_i;
  logic        biu_clk_i;
  logic        rst_i;
  logic        strobe_i;
  logic        rd_wrn_i;
  logic [31:0] data_i;
  logic [31:0] addr_i;
  logic [2:0]  word_size_i;
  logic [31:0] data_o;
  logic        rdy_o;
  logic        err_o;
  logic [31:0] biu_dat_i;
  logic        biu_ack_i;
  logic        biu_err_i;
  logic [31:0] biu_adr_o;
  logic [31:0] biu_dat_o;
  logic [3:0]  biu_sel_o;
  logic        biu_we_o;
  logic        biu_cyc_o;
  logic        biu_stb_o;
  int unsigned mem_cycles;

  vec_t        vectors[$];
  int          errors;
  int          checks;
  int          accepted;

  // Cycle monitor state, held fields during wait states, seen at the ack
  logic        in_cycle;
  int          bus_len;
  logic [31:0] held_adr;
  logic [31:0] held_dat;
  logic [3:0]  held_sel;
  logic        held_we;
  logic [31:0] seen_adr;
  logic [31:0] seen_dat;
  logic [3:0]  seen_sel;
  logic        seen_we;

  dbg_biu_top i_dut (
    .tck_i       (tck_i),
    .biu_clk_i   (biu_clk_i),
    .rst_i       (rst_i),
    .strobe_i    (strobe_i),
    .rd_wrn_i    (rd_wrn_i),
    .data_i      (data_i),
    .addr_i      (addr_i),
    .word_size_i (word_size_i),
    .data_o      (data_o),
    .rdy_o       (rdy_o),
    .err_o       (err_o),
    .biu_dat_i   (biu_dat_i),
    .biu_ack_i   (biu_ack_i),
    .biu_err_i   (biu_err_i),
    .biu_adr_o   (biu_adr_o),
    .biu_dat_o   (biu_dat_o),
    .biu_sel_o   (biu_sel_o),
    .biu_we_o    (biu_we_o),
    .biu_cyc_o   (biu_cyc_o),
    .biu_stb_o   (biu_stb_o)
  );

  tb_wb_mem_model #(
    .ERR_BASE (ERR_BASE),
    .ERR_LAST (ERR_LAST)
  ) i_mem (
    .clk_i    (biu_clk_i),
    .rst_i    (rst_i),
    .adr_i    (biu_adr_o),
    .dat_i    (biu_dat_o),
    .sel_i    (biu_sel_o),
    .we_i     (biu_we_o),
    .cyc_i    (biu_cyc_o),
    .stb_i    (biu_stb_o),
    .dat_o    (biu_dat_i),
    .ack_o    (biu_ack_i),
    .err_o    (biu_err_i),
    .cycles_o (mem_cycles)
  );

  // Bus clock 40 ns
  initial begin
    biu_clk_i = 1'b0;
    forever #20 biu_clk_i = ~biu_clk_i;
  end

  // JTAG clock 100 ns
  initial begin
    tck_i = 1'b0;
    forever #50 tck_i = ~tck_i;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone cycle monitor
  ////////////////////////////////////////////////////////////////////////////

  // cyc, stb and the request fields must hold through every wait state
  always @(posedge biu_clk_i) begin
    if (!rst_i) begin
      if (in_cycle) begin
        check("biu_cyc_o", biu_cyc_o, 1'b1);
        check("biu_stb_o", biu_stb_o, 1'b1);
        check("biu_adr_o", biu_adr_o, held_adr);
        check("biu_dat_o", biu_dat_o, held_dat);
        check("biu_sel_o", biu_sel_o, held_sel);
        check("biu_we_o", biu_we_o, held_we);
      end
      if (biu_cyc_o && biu_stb_o && (biu_ack_i || biu_err_i)) begin
        // Last clock of the cycle
        seen_adr = biu_adr_o;
        seen_dat = biu_dat_o;
        seen_sel = biu_sel_o;
        seen_we  = biu_we_o;
        in_cycle = 1'b0;
        bus_len  = 0;
      end else if (biu_cyc_o && biu_stb_o) begin
        if (!in_cycle) begin
          held_adr = biu_adr_o;
          held_dat = biu_dat_o;
          held_sel = biu_sel_o;
          held_we  = biu_we_o;
        end
        in_cycle = 1'b1;
        bus_len++;
        if (bus_len > BUS_TIMEOUT) begin
          $display("Timeout: bus cycle at 0x%h never got ack or error", biu_adr_o);
          errors++;
          in_cycle = 1'b0;
          bus_len  = 0;
        end
      end else begin
        in_cycle = 1'b0;
        bus_len  = 0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table and access tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_entry(input bit rd, input logic [2:0] size, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] sel,
                           input logic [31:0] bus_wdata, input logic [31:0] rdata,
                           input bit err, input bit dup);
    vec_t v;
    v = '{rd, size, addr, wdata, sel, bus_wdata, rdata, err, dup};
    vectors.push_back(v);
  endtask

  // Expected lanes and data follow the big-endian rule by hand
  task automatic fill_table();
    add_entry(WR, SZ_W, 32'h10, 32'h1234_5678, 4'b1111, 32'h1234_5678, 32'h0, 0, 0);
    add_entry(RD, SZ_W, 32'h10, 32'h0, 4'b1111, 32'h0, 32'h1234_5678, 0, 0);
    // Unknown size codes act as words
    add_entry(WR, 3'd7, 32'h14, 32'h0bad_f00d, 4'b1111, 32'h0bad_f00d, 32'h0, 0, 0);
    add_entry(RD, 3'd0, 32'h14, 32'h0, 4'b1111, 32'h0, 32'h0bad_f00d, 0, 0);
    // Bytes at every offset, low bits of data_i must not reach the bus
    add_entry(WR, SZ_B, 32'h20, 32'ha15a_5a5a, 4'b1000, 32'ha100_0000, 32'h0, 0, 0);
    add_entry(WR, SZ_B, 32'h21, 32'hb25a_5a5a, 4'b0100, 32'h00b2_0000, 32'h0, 0, 0);
    add_entry(WR, SZ_B, 32'h22, 32'hc35a_5a5a, 4'b0010, 32'h0000_c300, 32'h0, 0, 0);
    add_entry(WR, SZ_B, 32'h23, 32'hd45a_5a5a, 4'b0001, 32'h0000_00d4, 32'h0, 0, 0);
    add_entry(RD, SZ_W, 32'h20, 32'h0, 4'b1111, 32'h0, 32'ha1b2_c3d4, 0, 0);
    add_entry(RD, SZ_B, 32'h20, 32'h0, 4'b1000, 32'h0, 32'h0000_00a1, 0, 0);
    add_entry(RD, SZ_B, 32'h21, 32'h0, 4'b0100, 32'h0, 32'h0000_00b2, 0, 0);
    add_entry(RD, SZ_B, 32'h22, 32'h0, 4'b0010, 32'h0, 32'h0000_00c3, 0, 0);
    add_entry(RD, SZ_B, 32'h23, 32'h0, 4'b0001, 32'h0, 32'h0000_00d4, 0, 0);
    add_entry(RD, SZ_H, 32'h20, 32'h0, 4'b1100, 32'h0, 32'h0000_a1b2, 0, 0);
    // Halfwords in both halves
    add_entry(WR, SZ_H, 32'h30, 32'hbeef_1234, 4'b1100, 32'hbeef_0000, 32'h0, 0, 0);
    add_entry(WR, SZ_H, 32'h32, 32'hcafe_5678, 4'b0011, 32'h0000_cafe, 32'h0, 0, 0);
    add_entry(RD, SZ_H, 32'h30, 32'h0, 4'b1100, 32'h0, 32'h0000_beef, 0, 0);
    add_entry(RD, SZ_H, 32'h32, 32'h0, 4'b0011, 32'h0, 32'h0000_cafe, 0, 0);
    add_entry(RD, SZ_W, 32'h30, 32'h0, 4'b1111, 32'h0, 32'hbeef_cafe, 0, 0);
    // Error window, then a good access clears err_o
    add_entry(WR, SZ_W, 32'h104, 32'hdead_beef, 4'b1111, 32'hdead_beef, 32'h0, 1, 0);
    add_entry(RD, SZ_W, 32'h10, 32'h0, 4'b1111, 32'h0, 32'h1234_5678, 0, 0);
    add_entry(RD, SZ_B, 32'h10b, 32'h0, 4'b0001, 32'h0, 32'h0, 1, 0);
    // Strobe held while busy
    add_entry(RD, SZ_H, 32'h22, 32'h0, 4'b0011, 32'h0, 32'h0000_c3d4, 0, 1);
    add_entry(WR, SZ_W, 32'h0c, 32'h0, 4'b1111, 32'h0, 32'h0, 0, 0);
    add_entry(WR, SZ_B, 32'h0d, 32'h77a5_a5a5, 4'b0100, 32'h0077_0000, 32'h0, 0, 1);
    add_entry(RD, SZ_W, 32'h0c, 32'h0, 4'b1111, 32'h0, 32'h0077_0000, 0, 0);
  endtask

  task automatic wait_ready(output bit ok);
    int cycles;
    cycles = 0;
    while (!rdy_o && cycles < RDY_TIMEOUT) begin
      @(posedge tck_i);
      #2;
      cycles++;
    end
    ok = rdy_o;
    if (!ok) begin
      $display("Timeout: rdy_o did not come back within %0d tck cycles", RDY_TIMEOUT);
      errors++;
    end
  endtask

  // Entered 2 ns after a tck edge with rdy_o high
  task automatic run_access(input vec_t v);
    bit ok;
    rd_wrn_i    = v.rd;
    word_size_i = v.size;
    addr_i      = v.addr;
    data_i      = v.wdata;
    strobe_i    = 1'b1;
    @(posedge tck_i);
    #2;
    accepted++;
    // Two more strobes while busy, both must be dropped
    if (v.dup) begin
      repeat (2) begin
        check("rdy_o", rdy_o, 1'b0);
        @(posedge tck_i);
        #2;
      end
    end
    strobe_i = 1'b0;
    wait_ready(ok);
    if (ok) begin
      check("err_o", err_o, v.err);
      check("biu_adr_o", seen_adr, v.addr);
      check("biu_sel_o", seen_sel, v.sel);
      check("biu_we_o", seen_we, !v.rd);
      if (!v.rd) begin
        check("biu_dat_o", seen_dat, v.bus_wdata);
      end
      if (v.rd && !v.err) begin
        check("data_o", data_o, v.rdata);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_i       = 1'b1;
    strobe_i    = 1'b0;
    rd_wrn_i    = 1'b1;
    data_i      = '0;
    addr_i      = '0;
    word_size_i = SZ_W;
    errors      = 0;
    checks      = 0;
    accepted    = 0;
    in_cycle    = 1'b0;
    bus_len     = 0;
    seen_adr    = '0;
    seen_dat    = '0;
    seen_sel    = '0;
    seen_we     = 1'b0;
    fill_table();
    repeat (8) @(posedge biu_clk_i);
    #2;
    rst_i = 1'b0;
    @(posedge tck_i);
    #2;
    // Idle outputs straight after reset
    check("rdy_o", rdy_o, 1'b1);
    check("biu_cyc_o", biu_cyc_o, 1'b0);
    check("biu_stb_o", biu_stb_o, 1'b0);
    check("err_o", err_o, 1'b0);
    check("data_o", data_o, 32'h0);
    foreach (vectors[i]) begin
      run_access(vectors[i]);
    end
    // One bus cycle per accepted strobe, none for ignored ones
    check("bus cycle count", mem_cycles, accepted);
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
common/dbg_biu_pkg.sv
common/dbg_biu_xfer_if.sv
biu/dbg_biu_tck_side.sv
biu/dbg_biu_wb_master.sv
src/dbg_biu_top.sv
testbench/tb_wb_mem_model.sv
testbench/tb_dbg_biu.sv

/* Bender.yml */
package:
  name: dbg_biu

sources:
  - common/dbg_biu_pkg.sv
  - common/dbg_biu_xfer_if.sv
  - biu/dbg_biu_tck_side.sv
  - biu/dbg_biu_wb_master.sv
  - src/dbg_biu_top.sv
  - target: test
    files:
      - testbench/tb_wb_mem_model.sv
      - testbench/tb_dbg_biu.sv

# Simulation top: tb_dbg_biu
# Synthesis top: dbg_biu_top
